//--- common/vga_timing_pkg.sv
//********************
// Display timing types for the CRTC, the fetch
// controller and the palette output stage
//********************

`default_nettype none

package vga_timing_pkg;

  // Horizontal position and horizontal timing values, in pixels
  typedef logic [9:0] hcount_t;

  // Vertical position and vertical timing values, in lines
  typedef logic [9:0] vcount_t;

  // Runtime display timing
  // All values count from zero at the first active pixel or line
  typedef struct packed {
    // Visible pixels per line
    hcount_t h_active;
    // First pixel of horizontal sync
    hcount_t h_sync_start;
    // First pixel after horizontal sync
    hcount_t h_sync_end;
    // Pixels per line, blanking included
    hcount_t h_total;
    // Visible lines per frame
    vcount_t v_active;
    // First line of vertical sync
    vcount_t v_sync_start;
    // First line after vertical sync
    vcount_t v_sync_end;
    // Lines per frame, blanking included
    vcount_t v_total;
  } timing_cfg_t;

  // 12-bit colour as driven to the pads
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  // Colour index, one byte per pixel
  typedef logic [7:0] pal_idx_t;

endpackage

`default_nettype wire

//--- common/vga_mem_pkg.sv
//********************
// Video memory types and burst constants shared
// by the fetch path and the memory model
//********************

`default_nettype none

package vga_mem_pkg;

  // Word address into 1M words of video memory
  typedef logic [19:0] vaddr_t;

  // Video word, two pixels, low byte shown first
  typedef logic [15:0] vword_t;

  // Words per burst on either bus
  localparam int BURST_LEN = 8;

  // Fetch FSM states
  typedef enum logic [2:0] {
    // Waiting for FIFO room or a frame restart
    FETCH_IDLE,
    // First cache strobe of the burst
    FETCH_PROBE,
    // Hit check, then words from the cache bus
    FETCH_CACHE,
    // Memory bus strobe held until ack
    FETCH_MEM_WAIT,
    // Words from the memory bus after ack
    FETCH_MEM_STREAM
  } fetch_state_e;

endpackage

`default_nettype wire

//--- src/vga_crtc.sv
//********************
// CRTC timing generator
// Pixel tick divider, raster counters, syncs,
// display enable and frame start
//********************

`timescale 1ns/1ps
`default_nettype none

module vga_crtc #(
  parameter int PIX_DIV = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  vga_timing_pkg::timing_cfg_t timing_cfg_i,
  output logic                        pix_en_o,
  output logic                        video_on_o,
  output logic                        hsync_o,
  output logic                        vsync_o,
  output logic                        frame_start_o
);

  localparam int DIV_W = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;

  logic [DIV_W-1:0]        div_cnt;
  vga_timing_pkg::hcount_t h_cnt;
  vga_timing_pkg::vcount_t v_cnt;
  logic                    h_last;
  logic                    v_last;

  // One tick every PIX_DIV clocks
  assign pix_en_o = (div_cnt == DIV_W'(PIX_DIV - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
    end else if (pix_en_o) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign h_last = (h_cnt == timing_cfg_i.h_total - 10'd1);
  assign v_last = (v_cnt == timing_cfg_i.v_total - 10'd1);

  // Raster counters
  // Start at vertical sync so the FIFO fills before the first visible line
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= timing_cfg_i.v_sync_start;
    end else if (pix_en_o) begin
      if (h_last) begin
        h_cnt <= '0;
        v_cnt <= v_last ? '0 : v_cnt + 10'd1;
      end else begin
        h_cnt <= h_cnt + 10'd1;
      end
    end
  end

  // Sync windows, end value excluded
  assign hsync_o = (h_cnt >= timing_cfg_i.h_sync_start) &&
                   (h_cnt < timing_cfg_i.h_sync_end);
  assign vsync_o = (v_cnt >= timing_cfg_i.v_sync_start) &&
                   (v_cnt < timing_cfg_i.v_sync_end);

  assign video_on_o = (h_cnt < timing_cfg_i.h_active) &&
                      (v_cnt < timing_cfg_i.v_active);

  // First tick of the vsync line
  assign frame_start_o = pix_en_o && (h_cnt == '0) &&
                         (v_cnt == timing_cfg_i.v_sync_start);

endmodule

`default_nettype wire

//--- fetch/vga_fetch_ctrl.sv
//********************
// Video fetch controller
// Bursts of eight words into the pixel FIFO, cache
// bus first, memory bus on a miss
//********************

`timescale 1ns/1ps
`default_nettype none

module vga_fetch_ctrl #(
  parameter int FIFO_DEPTH_LOG2 = 6
) (
  input  logic                        clk,
  input  logic                        rst,
  input  vga_timing_pkg::timing_cfg_t timing_cfg_i,
  input  vga_mem_pkg::vaddr_t         start_addr_i,
  input  logic                        frame_start_i,
  input  logic [FIFO_DEPTH_LOG2:0]    free_count_i,
  output logic                        push_o,
  output vga_mem_pkg::vword_t         push_data_o,
  output logic                        flush_o,
  output logic                        dcb_stb_o,
  output vga_mem_pkg::vaddr_t         dcb_adr_o,
  input  vga_mem_pkg::vword_t         dcb_dat_i,
  input  logic                        dcb_hit_i,
  output logic                        mem_stb_o,
  output vga_mem_pkg::vaddr_t         mem_adr_o,
  input  logic                        mem_ack_i,
  input  vga_mem_pkg::vword_t         mem_dat_i
);

  localparam int BURST_W = $clog2(vga_mem_pkg::BURST_LEN);
  localparam int FREE_W  = FIFO_DEPTH_LOG2 + 1;

  vga_mem_pkg::fetch_state_e state_q;
  vga_mem_pkg::fetch_state_e state_d;
  logic [BURST_W-1:0]        beat_q;
  logic [BURST_W-1:0]        dcb_idx;
  logic                      first_beat;
  logic                      last_beat;
  logic                      restart_q;
  logic                      can_burst;
  logic                      cache_push;
  logic [19:0]               pix_count;
  vga_mem_pkg::vaddr_t       frame_words;
  vga_mem_pkg::vaddr_t       word_off_q;
  vga_mem_pkg::vaddr_t       burst_sum;
  vga_mem_pkg::vaddr_t       burst_adr;

  // Two pixels per word
  assign pix_count   = timing_cfg_i.h_active * timing_cfg_i.v_active;
  assign frame_words = {1'b0, pix_count[19:1]};

  // Burst base, offset only moves between bursts
  assign burst_sum = start_addr_i + word_off_q;
  assign burst_adr = {burst_sum[19:BURST_W], {BURST_W{1'b0}}};

  assign first_beat = (beat_q == '0);
  assign last_beat  = (beat_q == BURST_W'(vga_mem_pkg::BURST_LEN - 1));

  // Room for a whole burst and words still left in the frame
  assign can_burst = (free_count_i >= FREE_W'(vga_mem_pkg::BURST_LEN)) &&
                     (word_off_q < frame_words);

  always_comb begin
    state_d = state_q;
    case (state_q)
      vga_mem_pkg::FETCH_IDLE: begin
        // Pending restart wins over a new burst
        if (!restart_q && can_burst) begin
          state_d = vga_mem_pkg::FETCH_PROBE;
        end
      end
      vga_mem_pkg::FETCH_PROBE: begin
        state_d = vga_mem_pkg::FETCH_CACHE;
      end
      vga_mem_pkg::FETCH_CACHE: begin
        if (first_beat && !dcb_hit_i) begin
          state_d = vga_mem_pkg::FETCH_MEM_WAIT;
        end else if (last_beat) begin
          state_d = vga_mem_pkg::FETCH_IDLE;
        end
      end
      vga_mem_pkg::FETCH_MEM_WAIT: begin
        if (mem_ack_i) begin
          state_d = vga_mem_pkg::FETCH_MEM_STREAM;
        end
      end
      vga_mem_pkg::FETCH_MEM_STREAM: begin
        if (last_beat) begin
          state_d = vga_mem_pkg::FETCH_IDLE;
        end
      end
      default: state_d = vga_mem_pkg::FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= vga_mem_pkg::FETCH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Miss on the first beat pushes nothing
  assign cache_push = (state_q == vga_mem_pkg::FETCH_CACHE) && (!first_beat || dcb_hit_i);
  assign push_o      = cache_push || (state_q == vga_mem_pkg::FETCH_MEM_STREAM);
  assign push_data_o = (state_q == vga_mem_pkg::FETCH_CACHE) ? dcb_dat_i : mem_dat_i;

  // Beat count, zero outside data cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      beat_q <= '0;
    end else if (push_o) begin
      beat_q <= beat_q + 1'b1;
    end else begin
      beat_q <= '0;
    end
  end

  // Cache strobe runs one word ahead of the data
  // held through the line once the probe hits
  assign dcb_stb_o = (state_q == vga_mem_pkg::FETCH_PROBE) || (cache_push && !last_beat);
  assign dcb_idx   = (state_q == vga_mem_pkg::FETCH_PROBE) ? '0 : beat_q + 1'b1;
  assign dcb_adr_o = {burst_adr[19:BURST_W], dcb_idx};

  // Memory request held until ack
  assign mem_stb_o = (state_q == vga_mem_pkg::FETCH_MEM_WAIT);
  assign mem_adr_o = burst_adr;

  // Restart request from the CRTC, served when idle
  always_ff @(posedge clk) begin
    if (rst) begin
      restart_q <= 1'b0;
    end else if (frame_start_i) begin
      restart_q <= 1'b1;
    end else if (state_q == vga_mem_pkg::FETCH_IDLE) begin
      restart_q <= 1'b0;
    end
  end

  assign flush_o = restart_q && (state_q == vga_mem_pkg::FETCH_IDLE);

  // Running word offset into the frame
  always_ff @(posedge clk) begin
    if (rst || flush_o) begin
      word_off_q <= '0;
    end else if (push_o && last_beat) begin
      word_off_q <= word_off_q + 20'(vga_mem_pkg::BURST_LEN);
    end
  end

endmodule

`default_nettype wire

//--- src/vga_pixel_fifo.sv
//********************
// Pixel word FIFO
// Head word on dout, free-space count, flush
//********************

`timescale 1ns/1ps
`default_nettype none

module vga_pixel_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 6
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     flush_i,
  input  logic                     push_i,
  input  vga_mem_pkg::vword_t      din_i,
  input  logic                     pop_i,
  output vga_mem_pkg::vword_t      dout_o,
  output logic                     empty_o,
  output logic [FIFO_DEPTH_LOG2:0] free_count_o
);

  localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

  vga_mem_pkg::vword_t        mem [DEPTH];
  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
  logic [FIFO_DEPTH_LOG2:0]   count;
  logic                       do_push;
  logic                       do_pop;

  // Push when full and pop when empty are dropped
  assign do_push = push_i && (count != (FIFO_DEPTH_LOG2 + 1)'(DEPTH));
  assign do_pop  = pop_i && (count != '0);

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din_i;
    end
  end

  // Flush empties in one clock
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + do_push - do_pop;
    end
  end

  assign dout_o       = mem[rd_ptr];
  assign empty_o      = (count == '0);
  assign free_count_o = (FIFO_DEPTH_LOG2 + 1)'(DEPTH) - count;

endmodule

`default_nettype wire

//--- src/vga_palette_out.sv
//********************
// Palette output stage
// Byte to colour lookup, registered pads and
// sticky underflow flag
//********************

`timescale 1ns/1ps
`default_nettype none

module vga_palette_out (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     pix_en_i,
  input  logic                     video_on_i,
  input  logic                     hsync_i,
  input  logic                     vsync_i,
  input  vga_mem_pkg::vword_t      fifo_dout_i,
  input  logic                     fifo_empty_i,
  output logic                     fifo_pop_o,
  input  logic                     pal_we_i,
  input  vga_timing_pkg::pal_idx_t pal_addr_i,
  input  vga_timing_pkg::rgb_t     pal_data_i,
  output vga_timing_pkg::rgb_t     rgb_o,
  output logic                     hsync_o,
  output logic                     vsync_o,
  output logic                     underflow_o
);

  vga_timing_pkg::rgb_t     pal_mem [256];
  vga_timing_pkg::pal_idx_t pix_idx;
  logic                     half_q;
  logic                     pix_valid;

  // Palette write port
  always_ff @(posedge clk) begin
    if (pal_we_i) begin
      pal_mem[pal_addr_i] <= pal_data_i;
    end
  end

  // Low byte first, then high byte
  assign pix_idx   = half_q ? fifo_dout_i[15:8] : fifo_dout_i[7:0];
  assign pix_valid = video_on_i && !fifo_empty_i;

  // Word retired on the tick that shows its high byte
  assign fifo_pop_o = pix_en_i && pix_valid && half_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rgb_o       <= '0;
      hsync_o     <= 1'b0;
      vsync_o     <= 1'b0;
      half_q      <= 1'b0;
      underflow_o <= 1'b0;
    end else if (pix_en_i) begin
      hsync_o <= hsync_i;
      vsync_o <= vsync_i;
      // Black in blanking and on starvation
      rgb_o   <= pix_valid ? pal_mem[pix_idx] : '0;
      // Byte phase restarts every line
      half_q  <= video_on_i ? ~half_q : 1'b0;
      if (video_on_i && fifo_empty_i) begin
        underflow_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/vga_lcd.sv
//********************
// Framebuffer display controller top
// CRTC, fetch, pixel FIFO and palette output
//********************

`timescale 1ns/1ps
`default_nettype none

module vga_lcd #(
  parameter int PIX_DIV         = 4,
  parameter int FIFO_DEPTH_LOG2 = 6
) (
  input  logic                        clk,
  input  logic                        rst,
  // Static configuration
  input  vga_timing_pkg::timing_cfg_t timing_cfg_i,
  input  vga_mem_pkg::vaddr_t         start_addr_i,
  // Palette write port
  input  logic                        pal_we_i,
  input  vga_timing_pkg::pal_idx_t    pal_addr_i,
  input  vga_timing_pkg::rgb_t        pal_data_i,
  // Direct cache bus
  output logic                        dcb_stb_o,
  output vga_mem_pkg::vaddr_t         dcb_adr_o,
  input  vga_mem_pkg::vword_t         dcb_dat_i,
  input  logic                        dcb_hit_i,
  // Memory bus, read only
  output logic                        mem_stb_o,
  output vga_mem_pkg::vaddr_t         mem_adr_o,
  input  logic                        mem_ack_i,
  input  vga_mem_pkg::vword_t         mem_dat_i,
  // Pads
  output vga_timing_pkg::rgb_t        vga_rgb_o,
  output logic                        vga_hsync_o,
  output logic                        vga_vsync_o,
  output logic                        underflow_o
);

  // CRTC to palette stage and fetch
  logic pix_en;
  logic video_on;
  logic h_sync;
  logic v_sync;
  logic frame_start;

  // FIFO handshake
  logic                     fifo_push;
  vga_mem_pkg::vword_t      fifo_din;
  logic                     fifo_flush;
  logic                     fifo_pop;
  vga_mem_pkg::vword_t      fifo_dout;
  logic                     fifo_empty;
  logic [FIFO_DEPTH_LOG2:0] free_count;

  vga_crtc #(
    .PIX_DIV (PIX_DIV)
  ) u_crtc (
    .clk           (clk),
    .rst           (rst),
    .timing_cfg_i  (timing_cfg_i),
    .pix_en_o      (pix_en),
    .video_on_o    (video_on),
    .hsync_o       (h_sync),
    .vsync_o       (v_sync),
    .frame_start_o (frame_start)
  );

  vga_fetch_ctrl #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) u_fetch_ctrl (
    .clk           (clk),
    .rst           (rst),
    .timing_cfg_i  (timing_cfg_i),
    .start_addr_i  (start_addr_i),
    .frame_start_i (frame_start),
    .free_count_i  (free_count),
    .push_o        (fifo_push),
    .push_data_o   (fifo_din),
    .flush_o       (fifo_flush),
    .dcb_stb_o     (dcb_stb_o),
    .dcb_adr_o     (dcb_adr_o),
    .dcb_dat_i     (dcb_dat_i),
    .dcb_hit_i     (dcb_hit_i),
    .mem_stb_o     (mem_stb_o),
    .mem_adr_o     (mem_adr_o),
    .mem_ack_i     (mem_ack_i),
    .mem_dat_i     (mem_dat_i)
  );

  vga_pixel_fifo #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) u_pixel_fifo (
    .clk          (clk),
    .rst          (rst),
    .flush_i      (fifo_flush),
    .push_i       (fifo_push),
    .din_i        (fifo_din),
    .pop_i        (fifo_pop),
    .dout_o       (fifo_dout),
    .empty_o      (fifo_empty),
    .free_count_o (free_count)
  );

  vga_palette_out u_palette_out (
    .clk          (clk),
    .rst          (rst),
    .pix_en_i     (pix_en),
    .video_on_i   (video_on),
    .hsync_i      (h_sync),
    .vsync_i      (v_sync),
    .fifo_dout_i  (fifo_dout),
    .fifo_empty_i (fifo_empty),
    .fifo_pop_o   (fifo_pop),
    .pal_we_i     (pal_we_i),
    .pal_addr_i   (pal_addr_i),
    .pal_data_i   (pal_data_i),
    .rgb_o        (vga_rgb_o),
    .hsync_o      (vga_hsync_o),
    .vsync_o      (vga_vsync_o),
    .underflow_o  (underflow_o)
  );

endmodule

`default_nettype wire

//--- bench/vga_mem_model.sv
//********************
// Video memory model for the testbench
// Cache bus hits per line mask, memory bus
// with programmable ack delay
//********************

`timescale 1ns/1ps
`default_nettype none

module vga_mem_model (
  input  logic                clk,
  input  logic                rst,
  input  logic [7:0]          hit_mask_i,
  input  logic [7:0]          ack_delay_i,
  input  logic                dcb_stb_i,
  input  vga_mem_pkg::vaddr_t dcb_adr_i,
  output vga_mem_pkg::vword_t dcb_dat_o,
  output logic                dcb_hit_o,
  input  logic                mem_stb_i,
  input  vga_mem_pkg::vaddr_t mem_adr_i,
  output logic                mem_ack_o,
  output vga_mem_pkg::vword_t mem_dat_o
);

  // 4K words, loaded by the testbench
  vga_mem_pkg::vword_t mem [4096];
  logic [7:0]          wait_cnt;
  logic [3:0]          beat;
  logic                streaming;
  vga_mem_pkg::vaddr_t base;

  // Upper address bits folded into the stored word
  function automatic vga_mem_pkg::vword_t word_at(vga_mem_pkg::vaddr_t a);
    return mem[a[11:0]] ^ {a[19:12], a[19:12]};
  endfunction

  // Cache answers one cycle after each strobe
  // hit decided by line address bits 5:3
  always_ff @(posedge clk) begin
    if (rst) begin
      dcb_hit_o <= 1'b0;
      dcb_dat_o <= '0;
    end else begin
      dcb_hit_o <= dcb_stb_i && hit_mask_i[dcb_adr_i[5:3]];
      dcb_dat_o <= word_at(dcb_adr_i);
    end
  end

  // Memory bus, ack after the delay, then eight words
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_ack_o <= 1'b0;
      mem_dat_o <= '0;
      wait_cnt  <= '0;
      beat      <= '0;
      streaming <= 1'b0;
      base      <= '0;
    end else begin
      mem_ack_o <= 1'b0;
      if (mem_ack_o) begin
        // First word in the cycle after the ack
        mem_dat_o <= word_at(base);
        beat      <= 4'd1;
        streaming <= 1'b1;
      end else if (streaming) begin
        mem_dat_o <= word_at(base + beat);
        beat      <= beat + 4'd1;
        if (beat == 4'd7) begin
          streaming <= 1'b0;
        end
      end else if (mem_stb_i) begin
        if (wait_cnt == ack_delay_i) begin
          mem_ack_o <= 1'b1;
          wait_cnt  <= '0;
          base      <= mem_adr_i;
        end else begin
          wait_cnt <= wait_cnt + 8'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_vga_lcd.sv
//********************
// Testbench for the display controller
// Table of timing rows, raster scoreboard on the pads,
// bus request monitor
//********************

`timescale 1ns/1ps
`default_nettype none

module tb_vga_lcd;

  localparam int PIX_DIV         = 4;
  localparam int FIFO_DEPTH_LOG2 = 6;
  localparam int N_ROWS          = 5;
  localparam int SYNC_TIMEOUT    = 2000;

  // One stimulus row with its expected underflow outcome
  typedef struct packed {
    vga_timing_pkg::timing_cfg_t cfg;
    vga_mem_pkg::vaddr_t         start;
    logic [7:0]                  hit_mask;
    logic [7:0]                  ack_delay;
    logic                        expect_uf;
  } row_t;

  logic                        clk;
  logic                        rst;
  vga_timing_pkg::timing_cfg_t cfg;
  vga_mem_pkg::vaddr_t         start_addr;
  logic                        pal_we;
  vga_timing_pkg::pal_idx_t    pal_addr;
  vga_timing_pkg::rgb_t        pal_data;
  logic [7:0]                  hit_mask;
  logic [7:0]                  ack_delay;
  logic                        dcb_stb;
  vga_mem_pkg::vaddr_t         dcb_adr;
  vga_mem_pkg::vword_t         dcb_dat;
  logic                        dcb_hit;
  logic                        mem_stb;
  vga_mem_pkg::vaddr_t         mem_adr;
  logic                        mem_ack;
  vga_mem_pkg::vword_t         mem_dat;
  vga_timing_pkg::rgb_t        vga_rgb;
  logic                        vga_hsync;
  logic                        vga_vsync;
  logic                        underflow;

  row_t                        rows [N_ROWS];
  vga_timing_pkg::timing_cfg_t cfg_a;
  vga_timing_pkg::timing_cfg_t cfg_b;
  // Bench copies of video memory and palette
  vga_mem_pkg::vword_t         img [4096];
  vga_timing_pkg::rgb_t        pal [256];
  int                          errors;
  int                          timeouts;
  int                          n_checks;
  int                          probes;
  int                          mem_reqs;
  logic                        stb_prev;

  always #4 clk = ~clk;

  vga_lcd #(
    .PIX_DIV         (PIX_DIV),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) i_dut (
    .clk          (clk),
    .rst          (rst),
    .timing_cfg_i (cfg),
    .start_addr_i (start_addr),
    .pal_we_i     (pal_we),
    .pal_addr_i   (pal_addr),
    .pal_data_i   (pal_data),
    .dcb_stb_o    (dcb_stb),
    .dcb_adr_o    (dcb_adr),
    .dcb_dat_i    (dcb_dat),
    .dcb_hit_i    (dcb_hit),
    .mem_stb_o    (mem_stb),
    .mem_adr_o    (mem_adr),
    .mem_ack_i    (mem_ack),
    .mem_dat_i    (mem_dat),
    .vga_rgb_o    (vga_rgb),
    .vga_hsync_o  (vga_hsync),
    .vga_vsync_o  (vga_vsync),
    .underflow_o  (underflow)
  );

  vga_mem_model i_mem (
    .clk         (clk),
    .rst         (rst),
    .hit_mask_i  (hit_mask),
    .ack_delay_i (ack_delay),
    .dcb_stb_i   (dcb_stb),
    .dcb_adr_i   (dcb_adr),
    .dcb_dat_o   (dcb_dat),
    .dcb_hit_o   (dcb_hit),
    .mem_stb_i   (mem_stb),
    .mem_adr_i   (mem_adr),
    .mem_ack_o   (mem_ack),
    .mem_dat_o   (mem_dat)
  );

  task step_clk;
    @(posedge clk);
    #1;
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
    end
  endtask

  // Same word layout as the model: upper address bits folded in
  function automatic vga_mem_pkg::vword_t word_at(vga_mem_pkg::vaddr_t a);
    return img[a[11:0]] ^ {a[19:12], a[19:12]};
  endfunction

  // Colour index of pixel p in raster order, low byte first
  function automatic vga_timing_pkg::pal_idx_t byte_at(int p);
    vga_mem_pkg::vword_t w;
    w = word_at(start_addr + vga_mem_pkg::vaddr_t'(p / 2));
    return (p % 2 == 1) ? w[15:8] : w[7:0];
  endfunction

  // Cache hit rule of the model, one mask bit per line
  function automatic logic line_hit(vga_mem_pkg::vaddr_t a);
    return hit_mask[a[5:3]];
  endfunction

  // Probe and memory request monitor
  always @(negedge clk) begin
    if (rst) begin
      stb_prev = 1'b0;
    end else begin
      // Rising cache strobe marks a probe
      if (dcb_stb && !stb_prev) begin
        probes++;
        check_val("dcb_adr_o[2:0]", 0, dcb_adr[2:0]);
      end
      if (mem_stb && mem_ack) begin
        mem_reqs++;
        check_val("mem_adr_o[2:0]", 0, mem_adr[2:0]);
      end
      stb_prev = dcb_stb;
    end
  end

  task automatic wait_vsync_rise(output logic found);
    logic prev;
    int   n;
    found = 1'b0;
    prev  = vga_vsync;
    for (n = 0; n < SYNC_TIMEOUT && !found; n++) begin
      step_clk;
      if (vga_vsync && !prev) begin
        found = 1'b1;
      end
      prev = vga_vsync;
    end
  endtask

  // Scoreboard over two frames, first sample is h 0 of the vsync line
  task automatic run_frames(input int r);
    int                       t;
    int                       h;
    int                       v;
    int                       frame;
    int                       ha;
    int                       hss;
    int                       hse;
    int                       ht;
    int                       va;
    int                       vss;
    int                       vse;
    int                       vt;
    int                       hs_width;
    int                       hs_period;
    int                       vs_ticks;
    int                       n_bursts;
    int                       n_miss;
    int                       k;
    logic                     hs_prev;
    logic                     vs_prev;
    logic                     uf_prev;
    vga_timing_pkg::rgb_t     exp_rgb;
    vga_timing_pkg::pal_idx_t idx;
    ha  = int'(cfg.h_active);
    hss = int'(cfg.h_sync_start);
    hse = int'(cfg.h_sync_end);
    ht  = int'(cfg.h_total);
    va  = int'(cfg.v_active);
    vss = int'(cfg.v_sync_start);
    vse = int'(cfg.v_sync_end);
    vt  = int'(cfg.v_total);
    h = 0;
    v = vss;
    frame = 0;
    hs_width = 0;
    hs_period = -1;
    vs_ticks = 0;
    hs_prev = 1'b0;
    vs_prev = 1'b0;
    uf_prev = underflow;
    for (t = 0; t < 2 * ht * vt; t++) begin
      check_val("vga_hsync_o", (h >= hss) && (h < hse), vga_hsync);
      check_val("vga_vsync_o", (v >= vss) && (v < vse), vga_vsync);
      // Widths and period in pixel ticks
      if (vga_hsync) begin
        hs_width++;
      end
      if (hs_prev && !vga_hsync) begin
        check_val("hsync width", hse - hss, hs_width);
        hs_width = 0;
      end
      if (!hs_prev && vga_hsync) begin
        if (hs_period >= 0) begin
          check_val("hsync period", ht, hs_period);
        end
        hs_period = 0;
      end
      if (hs_period >= 0) begin
        hs_period++;
      end
      if (vga_vsync) begin
        vs_ticks++;
      end
      if (vs_prev && !vga_vsync) begin
        check_val("vsync width", (vse - vss) * ht, vs_ticks);
        vs_ticks = 0;
      end
      exp_rgb = (h < ha && v < va) ? pal[byte_at(v * ha + h)] : '0;
      if (rows[r].expect_uf) begin
        // Black where starvation is first flagged, unchecked after
        if (underflow && !uf_prev) begin
          check_val("vga_rgb_o", 0, vga_rgb);
        end else if (!underflow) begin
          check_val("vga_rgb_o", exp_rgb, vga_rgb);
        end
      end else begin
        check_val("underflow_o", 0, underflow);
        check_val("vga_rgb_o", exp_rgb, vga_rgb);
      end
      uf_prev = underflow;
      hs_prev = vga_hsync;
      vs_prev = vga_vsync;
      // New colours for the first line's indices, in blanking after frame 1
      if (frame == 1 && v == va && h < ha) begin
        idx = byte_at(h);
        pal_addr = idx;
        pal_data = 12'($urandom);
        pal_we = 1'b1;
        pal[idx] = pal_data;
      end
      step_clk;
      pal_we = 1'b0;
      repeat (PIX_DIV - 1) step_clk;
      if (h == ht - 1) begin
        h = 0;
        if (v == vt - 1) begin
          v = 0;
          frame++;
        end else begin
          v++;
        end
      end else begin
        h++;
      end
    end
    // Flushed burst after reset plus one fetch of each frame
    n_bursts = (ha * va / 2 + vga_mem_pkg::BURST_LEN - 1) / vga_mem_pkg::BURST_LEN;
    n_miss = line_hit(start_addr) ? 0 : 1;
    for (k = 0; k < n_bursts; k++) begin
      if (!line_hit(start_addr + vga_mem_pkg::vaddr_t'(k * vga_mem_pkg::BURST_LEN))) begin
        n_miss += 2;
      end
    end
    if (rows[r].expect_uf) begin
      check_val("underflow_o", 1, underflow);
    end else begin
      check_val("cache probes", 1 + 2 * n_bursts, probes);
      check_val("memory requests", n_miss, mem_reqs);
    end
  endtask

  task automatic run_row(input int r);
    logic found;
    rst = 1'b1;
    cfg = rows[r].cfg;
    start_addr = rows[r].start;
    hit_mask = rows[r].hit_mask;
    ack_delay = rows[r].ack_delay;
    repeat (8) step_clk;
    check_val("vga_hsync_o", 0, vga_hsync);
    check_val("vga_vsync_o", 0, vga_vsync);
    check_val("underflow_o", 0, underflow);
    check_val("vga_rgb_o", 0, vga_rgb);
    check_val("dcb_stb_o", 0, dcb_stb);
    check_val("mem_stb_o", 0, mem_stb);
    probes = 0;
    mem_reqs = 0;
    rst = 1'b0;
    wait_vsync_rise(found);
    if (found) begin
      run_frames(r);
    end else begin
      timeouts++;
      $display("Timeout: no vsync rising edge after reset in row %0d", r);
    end
  endtask

  initial begin
    int i;
    clk = 1'b0;
    rst = 1'b1;
    pal_we = 1'b0;
    pal_addr = '0;
    pal_data = '0;
    start_addr = '0;
    hit_mask = '0;
    ack_delay = '0;
    errors = 0;
    timeouts = 0;
    n_checks = 0;
    void'($urandom(32'h583c_1768));
    // h_active, sync start, sync end, total, then the same for lines
    cfg_a = '{10'd16, 10'd18, 10'd21, 10'd24, 10'd4, 10'd5, 10'd6, 10'd8};
    cfg_b = '{10'd20, 10'd22, 10'd24, 10'd28, 10'd3, 10'd4, 10'd6, 10'd7};
    cfg = cfg_a;
    rows[0] = '{cfg_a, 20'h0_0000, 8'hFF, 8'd0, 1'b0};
    rows[1] = '{cfg_a, 20'h0_0100, 8'h00, 8'd2, 1'b0};
    rows[2] = '{cfg_b, 20'hA_5F40, 8'hA5, 8'd5, 1'b0};
    // Slow ack still done within vertical blanking
    rows[3] = '{cfg_a, 20'h0_0800, 8'h00, 8'd30, 1'b0};
    // Too slow to keep up
    rows[4] = '{cfg_a, 20'h0_0200, 8'h00, 8'd200, 1'b1};
    for (i = 0; i < 4096; i++) begin
      img[i] = 16'($urandom);
      i_mem.mem[i] = img[i];
    end
    // Palette load while in reset
    for (i = 0; i < 256; i++) begin
      pal_addr = 8'(i);
      pal_data = 12'($urandom);
      pal_we = 1'b1;
      pal[i] = pal_data;
      step_clk;
    end
    pal_we = 1'b0;
    for (i = 0; i < N_ROWS; i++) begin
      run_row(i);
    end
    $display("Rows %0d, checks %0d, errors %0d, timeouts %0d", N_ROWS, n_checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
common/vga_timing_pkg.sv
common/vga_mem_pkg.sv
src/vga_crtc.sv
fetch/vga_fetch_ctrl.sv
src/vga_pixel_fifo.sv
src/vga_palette_out.sv
src/vga_lcd.sv
bench/vga_mem_model.sv
bench/tb_vga_lcd.sv

//--- Bender.yml
package:
  name: vga_lcd

sources:
  - common/vga_timing_pkg.sv
  - common/vga_mem_pkg.sv
  - src/vga_crtc.sv
  - fetch/vga_fetch_ctrl.sv
  - src/vga_pixel_fifo.sv
  - src/vga_palette_out.sv
  - src/vga_lcd.sv
  - target: test
    files:
      - bench/vga_mem_model.sv
      - bench/tb_vga_lcd.sv
